// ==== odt_cfg_regs.sv ====
/* APB slave holding the ODT enable and the CAS read and write latencies
   zero wait states, unmapped addresses answer with pslverr */
`timescale 1ns/1ps

module odt_cfg_regs
(
    input  logic              ctl_clk,
    input  logic              ctl_reset_n,
    input  odt_pkg::apb_addr_t paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  odt_pkg::apb_data_t pwdata,
    output odt_pkg::apb_data_t prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              odt_enable,
    output odt_pkg::lat_t     mem_tcl,
    output odt_pkg::lat_t     mem_cas_wr_lat
);

    import odt_pkg::*;

    logic addr_hit;
    logic access;       // second cycle of a transfer
    logic wr_en;
    lat_t wr_lat;       // write data after the lower clamp

    // latencies below the supported minimum are stored as the minimum
    function automatic lat_t clamp_lat(input lat_t value);
        if (value < lat_t'(MIN_LAT))
            return lat_t'(MIN_LAT);
        return value;
    endfunction

    assign addr_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_TCL) || (paddr == ADDR_CWL);
    assign access   = psel && penable;
    assign wr_en    = access && pwrite && addr_hit;
    assign wr_lat   = clamp_lat(pwdata[LAT_W-1:0]);

    assign pready  = 1'b1;                   // no wait states
    assign pslverr = access && !addr_hit;

    ////////////////////
    // register storage
    ////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            odt_enable     <= 1'b1;
            mem_tcl        <= lat_t'(RESET_LAT);
            mem_cas_wr_lat <= lat_t'(RESET_LAT);
        end
        else if (wr_en)
        begin
            case (paddr)
                ADDR_CTRL: odt_enable     <= pwdata[0];
                ADDR_TCL:  mem_tcl        <= wr_lat;
                ADDR_CWL:  mem_cas_wr_lat <= wr_lat;
                default:   ;
            endcase
        end
    end

    // read mux, address is stable from the setup phase on
    always_comb
    begin
        prdata = '0;
        if (psel && !pwrite)
        begin
            case (paddr)
                ADDR_CTRL: prdata = {{(APB_DATA_W-1){1'b0}}, odt_enable};
                ADDR_TCL:  prdata = {{(APB_DATA_W-LAT_W){1'b0}}, mem_tcl};
                ADDR_CWL:  prdata = {{(APB_DATA_W-LAT_W){1'b0}}, mem_cas_wr_lat};
                default:   prdata = '0;     // unmapped reads return zero
            endcase
        end
    end

endmodule

// ==== odt_ctrl.sv ====
/* registers the write or read command and maps it onto the ranks to terminate
   DDR3 scheme with two ranks per DIMM, one start strobe per rank */
`timescale 1ns/1ps

module odt_ctrl
(
    input  logic               ctl_clk,
    input  logic               ctl_reset_n,
    input  logic               do_write,
    input  logic               do_read,
    input  odt_pkg::chip_vec_t to_chip,
    input  logic               odt_enable,
    output odt_pkg::chip_vec_t write_start,
    output odt_pkg::chip_vec_t read_start
);

    import odt_pkg::*;

    cmd_e      cmd_q;
    chip_vec_t chip_q;       // target chip of the registered command
    chip_vec_t partner;      // same position in the other DIMM
    chip_vec_t wr_ranks;
    chip_vec_t rd_ranks;

    ////////////////////
    // command register
    ////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            cmd_q <= CMD_IDLE;
        end
        else if (do_read)
        begin
            cmd_q <= CMD_READ;           // read wins over a write in the same cycle
        end
        else if (do_write)
        begin
            cmd_q <= CMD_WRITE;
        end
        else
        begin
            cmd_q <= CMD_IDLE;
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        chip_q <= to_chip;
    end

    ////////////////////
    // rank mapping
    ////////////////////

    /*
      write chip j  terminates chip j and chip j+2 (mod 4)
      write all     terminates all four chips
      read chip j   terminates only chip j+2 (mod 4)
    */
    always_comb
    begin
        for (int i = 0; i < NUM_CHIPS; i++)
        begin
            partner[i] = chip_q[(i + RANKS_PER_DIMM) % NUM_CHIPS];
        end
    end

    always_comb
    begin
        if (&chip_q)
            wr_ranks = '1;
        else
            wr_ranks = chip_q | partner;
    end

    assign rd_ranks = partner;

    // one cycle per command since cmd_q only holds for one cycle per strobe
    assign write_start = (odt_enable && cmd_q == CMD_WRITE) ? wr_ranks : '0;
    assign read_start  = (odt_enable && cmd_q == CMD_READ)  ? rd_ranks : '0;

endmodule

// ==== odt_gen.f ====
odt_pkg.sv
odt_cfg_regs.sv
odt_ctrl.sv
odt_rank_timer.sv
odt_gen_top.sv
odt_gen_checker.sv
odt_gen_tb.sv

// ==== odt_gen_checker.sv ====
/* assertions bound onto the ODT generator top
   covers the APB handshake and the idle state after reset */
`timescale 1ns/1ps

module odt_gen_checker
(
    input logic               ctl_clk,
    input logic               ctl_reset_n,
    input logic               psel,
    input logic               penable,
    input logic               pready,
    input logic               pslverr,
    input odt_pkg::chip_vec_t afi_odt
);

    int unsigned fail_count = 0;     // failed assertions so far

    // zero wait state slave
    a_pready_high : assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n) pready)
        else
        begin
            fail_count = fail_count + 1;
            $error("pready went low");
        end

    a_idle_after_reset : assert property (@(posedge ctl_clk) $rose(ctl_reset_n) |-> afi_odt == '0)
        else
        begin
            fail_count = fail_count + 1;
            $error("afi_odt active in the first cycle after reset release");
        end

    // slave error only while a transfer is in its access phase
    a_slverr_access : assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        pslverr |-> (psel && penable))
        else
        begin
            fail_count = fail_count + 1;
            $error("pslverr high outside an access phase");
        end

endmodule

// ==== odt_gen_tb.sv ====
/* directed testbench for the DDR3 ODT generator, APB setup and command tasks
   a cycle model predicts afi_odt and is compared at every falling edge */
`timescale 1ns/1ps

module odt_gen_tb;

    import odt_pkg::*;

    localparam int TIMEOUT = 64;   // cycles allowed for any wait

    logic        ctl_clk = 1'b0;
    logic        ctl_reset_n;
    apb_addr_t   paddr;
    logic        psel, penable, pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        do_write;
    logic        do_read;
    chip_vec_t   to_chip;
    chip_vec_t   afi_odt;

    int          mismatches = 0;
    int          failures   = 0;
    int unsigned lcg_state  = 90178;
    int          edge_num   = 0;
    chip_vec_t   exp_odt [32];     // expected afi_odt after each edge, ring buffer
    logic        sh_en;            // model copies of the registers
    lat_t        sh_tcl;
    lat_t        sh_cwl;

    odt_gen_top i_dut (.*);

    bind odt_gen_top odt_gen_checker i_checker (.*);

    always #4 ctl_clk = ~ctl_clk;

    function automatic int unsigned lcg_next(input int unsigned range);
        lcg_state = lcg_state * 1103515245 + 12345;
        return (lcg_state >> 16) % range;
    endfunction

    // a read terminates the partner rank only, a write the target and its partner
    function automatic chip_vec_t term_ranks(input logic is_read, input chip_vec_t chip);
        chip_vec_t r;
        r = '0;
        for (int j = 0; j < NUM_CHIPS; j++)
        begin
            if (chip[j])
            begin
                r[(j + RANKS_PER_DIMM) % NUM_CHIPS] = 1'b1;
                if (!is_read)
                    r[j] = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic lat_t raise_to_min(input apb_data_t d);
        return (d[LAT_W-1:0] < MIN_LAT) ? lat_t'(MIN_LAT) : d[LAT_W-1:0];
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    ////////////////////
    // reference model
    ////////////////////
    always @(posedge ctl_clk)
    begin
        chip_vec_t ranks;
        int        lat;
        edge_num = edge_num + 1;
        if (!ctl_reset_n)
        begin
            sh_en  = 1'b1;
            sh_tcl = lat_t'(RESET_LAT);
            sh_cwl = lat_t'(RESET_LAT);
        end
        else
        begin
            if (psel && penable && pwrite)      // register write lands at this edge
            begin
                case (paddr)
                    ADDR_CTRL: sh_en  = pwdata[0];
                    ADDR_TCL:  sh_tcl = raise_to_min(pwdata);
                    ADDR_CWL:  sh_cwl = raise_to_min(pwdata);
                    default:   ;
                endcase
            end
            if (sh_en && (do_write || do_read))
            begin
                ranks = term_ranks(do_read, to_chip);
                lat   = do_read ? sh_tcl : sh_cwl;  // read wins
                for (int k = 0; k < ODT_ON_CYCLES; k++)
                    exp_odt[(edge_num + lat + k) % 32] |= ranks;
            end
        end
    end

    always @(negedge ctl_clk)
    begin
        if (ctl_reset_n && afi_odt !== exp_odt[edge_num % 32])
            report_mismatch($sformatf("afi_odt %b, model %b", afi_odt,
                                      exp_odt[edge_num % 32]));
        exp_odt[edge_num % 32] = '0;
    end

    ////////////////////
    // bus and command tasks
    ////////////////////
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        int n;
        paddr  = addr;
        pwrite = wr;
        pwdata = wdata;
        psel   = 1'b1;
        @(posedge ctl_clk);
        #1 penable = 1'b1;
        n = 0;
        @(negedge ctl_clk);
        while (!pready && n < TIMEOUT)
        begin
            @(negedge ctl_clk);
            n++;
        end
        if (!pready)
            report_failure("APB transfer timed out waiting for pready");
        rdata = prdata;
        err   = pslverr;
        @(posedge ctl_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_transfer(1'b1, addr, data, rd, err);
        if (err !== exp_err)
            report_mismatch($sformatf("write 0x%h pslverr %b, expected %b", addr, err, exp_err));
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t exp_data, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_transfer(1'b0, addr, '0, rd, err);
        if (rd !== exp_data || err !== exp_err)
            report_mismatch($sformatf("read 0x%h gave %0d err %b, expected %0d err %b",
                                      addr, rd, err, exp_data, exp_err));
    endtask

    task automatic send_cmd(input logic wr, input logic rd, input chip_vec_t chip);
        do_write = wr;
        do_read  = rd;
        to_chip  = chip;
        @(posedge ctl_clk);
        #1;
        do_write = 1'b0;
        do_read  = 1'b0;
    endtask

    // lat counts edges from the command edge to the first edge with ODT high
    task automatic expect_odt(input chip_vec_t pattern, input int lat);
        int k;
        int width;
        k = 0;
        while (afi_odt == '0 && k < TIMEOUT)
        begin
            @(posedge ctl_clk);
            #1;
            k++;
        end
        if (afi_odt == '0)
        begin
            report_failure("no ODT window appeared before the timeout");
            return;
        end
        if (k != lat)
            report_mismatch($sformatf("ODT started after %0d cycles, expected %0d", k, lat));
        width = 0;
        while (afi_odt != '0 && width < TIMEOUT)
        begin
            if (afi_odt !== pattern)
                report_mismatch($sformatf("afi_odt %b, expected %b", afi_odt, pattern));
            @(posedge ctl_clk);
            #1;
            width++;
        end
        if (width != ODT_ON_CYCLES)
            report_mismatch($sformatf("ODT window %0d cycles, expected %0d", width, ODT_ON_CYCLES));
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic test_reset();
        apb_read(ADDR_CTRL, 1, 1'b0);
        apb_read(ADDR_TCL, RESET_LAT, 1'b0);
        apb_read(ADDR_CWL, RESET_LAT, 1'b0);
        repeat (20) @(posedge ctl_clk);    // model holds afi_odt at zero
        #1;
    endtask

    task automatic test_write_map();
        apb_write(ADDR_CWL, 7, 1'b0);
        for (int j = 0; j < NUM_CHIPS; j++)
        begin
            send_cmd(1'b1, 1'b0, chip_vec_t'(1 << j));
            expect_odt(chip_vec_t'((1 << j) | (1 << ((j + 2) % NUM_CHIPS))), 7);
        end
        send_cmd(1'b1, 1'b0, '1);
        expect_odt('1, 7);
    endtask

    task automatic test_read_map();
        apb_write(ADDR_TCL, 4, 1'b0);
        for (int j = 0; j < NUM_CHIPS; j++)
        begin
            send_cmd(1'b0, 1'b1, chip_vec_t'(1 << j));
            expect_odt(chip_vec_t'(1 << ((j + 2) % NUM_CHIPS)), 4);
        end
        send_cmd(1'b1, 1'b1, 4'b0010);     // read and write together
        expect_odt(4'b1000, 4);
    endtask

    task automatic test_pipeline();
        int kind;
        for (int round = 0; round < 4; round++)
        begin
            apb_write(ADDR_TCL, MIN_LAT + lcg_next(14), 1'b0);
            apb_write(ADDR_CWL, MIN_LAT + lcg_next(14), 1'b0);
            for (int c = 0; c < 40; c++)
            begin
                kind     = lcg_next(4);       // idle, write, read, both
                do_write = (kind == 1 || kind == 3);
                do_read  = (kind >= 2);
                to_chip  = (lcg_next(8) == 0) ? '1 : chip_vec_t'(1 << lcg_next(4));
                @(posedge ctl_clk);
                #1;
            end
            do_write = 1'b0;
            do_read  = 1'b0;
        end
        repeat (24) @(posedge ctl_clk);
        #1;
    endtask

    task automatic test_enable();
        apb_write(ADDR_CWL, 15, 1'b0);
        send_cmd(1'b1, 1'b0, 4'b0001);     // scheduled before the clear
        apb_write(ADDR_CTRL, 0, 1'b0);
        send_cmd(1'b1, 1'b0, 4'b0010);
        send_cmd(1'b0, 1'b1, 4'b1000);
        expect_odt(4'b0101, 11);          // 15 cycles minus 4 edges already passed
        apb_write(ADDR_CTRL, 1, 1'b0);
        send_cmd(1'b1, 1'b0, 4'b0010);
        expect_odt(4'b1010, 15);
    endtask

    task automatic test_registers();
        apb_write(ADDR_TCL, 0, 1'b0);
        apb_read(ADDR_TCL, MIN_LAT, 1'b0);
        apb_write(ADDR_TCL, 1, 1'b0);
        apb_read(ADDR_TCL, MIN_LAT, 1'b0);
        apb_write(4'hC, 32'h5, 1'b1);      // unmapped
        apb_read(4'hC, 0, 1'b1);
    endtask

    initial
    begin
        foreach (exp_odt[i])
            exp_odt[i] = '0;
        ctl_reset_n = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        do_write    = 1'b0;
        do_read     = 1'b0;
        to_chip     = '0;
        repeat (16) @(posedge ctl_clk);
        #1 ctl_reset_n = 1'b1;
        test_reset();
        test_write_map();
        test_read_map();
        test_pipeline();
        test_enable();
        test_registers();
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, i_dut.i_checker.fail_count);
        if (mismatches + failures + i_dut.i_checker.fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== odt_gen_top.sv ====
/* DDR3 ODT generator top, APB configuration, command mapping and one timer per rank
   afi_odt carries one termination bit per chip select */
`timescale 1ns/1ps

module odt_gen_top
(
    input  logic               ctl_clk,
    input  logic               ctl_reset_n,
    // APB configuration port
    input  odt_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  odt_pkg::apb_data_t pwdata,
    output odt_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    // commands from the controller state machine
    input  logic               do_write,
    input  logic               do_read,
    input  odt_pkg::chip_vec_t to_chip,   // one hot
    output odt_pkg::chip_vec_t afi_odt
);

    import odt_pkg::*;

    logic      odt_enable;
    lat_t      mem_tcl;
    lat_t      mem_cas_wr_lat;
    chip_vec_t write_start;
    chip_vec_t read_start;

    odt_cfg_regs i_cfg_regs
    (
        .ctl_clk        (ctl_clk),
        .ctl_reset_n    (ctl_reset_n),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .odt_enable     (odt_enable),
        .mem_tcl        (mem_tcl),
        .mem_cas_wr_lat (mem_cas_wr_lat)
    );

    odt_ctrl i_ctrl
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .do_write    (do_write),
        .do_read     (do_read),
        .to_chip     (to_chip),
        .odt_enable  (odt_enable),
        .write_start (write_start),
        .read_start  (read_start)
    );

    ////////////////////
    // one timer per rank
    ////////////////////
    for (genvar g = 0; g < NUM_CHIPS; g++)
    begin : g_rank
        odt_rank_timer i_rank_timer
        (
            .ctl_clk        (ctl_clk),
            .ctl_reset_n    (ctl_reset_n),
            .write_start    (write_start[g]),
            .read_start     (read_start[g]),
            .mem_tcl        (mem_tcl),
            .mem_cas_wr_lat (mem_cas_wr_lat),
            .odt            (afi_odt[g])
        );
    end

endmodule

// ==== odt_pkg.sv ====
/* shared widths, latency limits, APB register map and types for the DDR3 ODT generator
   imported by every RTL block and by the testbench model */
package odt_pkg;

    ////////////////////
    // memory topology
    ////////////////////
    localparam int NUM_CHIPS      = 4;          // chip selects, one ODT bit each
    localparam int RANKS_PER_DIMM = 2;          // also the offset to the partner rank

    ////////////////////
    // latency and window
    ////////////////////
    localparam int LAT_W         = 4;
    localparam int MIN_LAT       = 2;           // smaller writes are raised to this
    localparam int RESET_LAT     = 5;
    localparam int ODT_ON_CYCLES = 6;           // cycles of ODT per command

    // one pending slot per latency from MIN_LAT up to the largest LAT_W value
    localparam int PEND_DEPTH = (1 << LAT_W) - MIN_LAT;
    localparam int ODT_CNT_W  = $clog2(ODT_ON_CYCLES + 1);

    ////////////////////
    // APB register map
    ////////////////////
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL = 4'h0;  // bit 0 odt_enable
    localparam logic [APB_ADDR_W-1:0] ADDR_TCL  = 4'h4;  // CAS latency
    localparam logic [APB_ADDR_W-1:0] ADDR_CWL  = 4'h8;  // CAS write latency

    ////////////////////
    // types
    ////////////////////
    typedef logic [NUM_CHIPS-1:0]  chip_vec_t;   // to_chip, start strobes, afi_odt
    typedef logic [LAT_W-1:0]      lat_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [PEND_DEPTH-1:0] pend_vec_t;   // window starts still in flight
    typedef logic [ODT_CNT_W-1:0]  odt_cnt_t;    // cycles left in the open window

    // command kind after the input register
    typedef enum logic [1:0]
    {
        CMD_IDLE,
        CMD_WRITE,
        CMD_READ
    } cmd_e;

endpackage

// ==== odt_rank_timer.sv ====
/* ODT window timer for one rank, start strobes wait out their latency in a shift vector
   a mark reaching the front opens or extends an ODT_ON_CYCLES window */
`timescale 1ns/1ps

module odt_rank_timer
(
    input  logic          ctl_clk,
    input  logic          ctl_reset_n,
    input  logic          write_start,
    input  logic          read_start,
    input  odt_pkg::lat_t mem_tcl,
    input  odt_pkg::lat_t mem_cas_wr_lat,
    output logic          odt
);

    import odt_pkg::*;

    pend_vec_t pend_q;
    pend_vec_t pend_d;
    odt_cnt_t  cnt_q;
    int        wr_idx;
    int        rd_idx;

    // slot 0 is due at the next edge, so latency L maps to slot L-MIN_LAT
    function automatic int lat_to_idx(input lat_t lat);
        if (lat < lat_t'(MIN_LAT))
            return 0;
        return int'(lat) - MIN_LAT;
    endfunction

    assign wr_idx = lat_to_idx(mem_cas_wr_lat);
    assign rd_idx = lat_to_idx(mem_tcl);

    always_comb
    begin
        pend_d = pend_q >> 1;        // every mark moves one slot closer
        if (write_start)
            pend_d[wr_idx] = 1'b1;
        if (read_start)
            pend_d[rd_idx] = 1'b1;
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            pend_q <= '0;
            cnt_q  <= '0;
        end
        else
        begin
            pend_q <= pend_d;
            if (pend_q[0])
                cnt_q <= odt_cnt_t'(ODT_ON_CYCLES);  // restart, overlapping windows merge
            else if (cnt_q != '0)
                cnt_q <= cnt_q - 1'b1;
        end
    end

    assign odt = (cnt_q != '0);

endmodule
